// ==== rv_csr_pkg.sv ====
// RISC-V machine CSR definitions
`default_nettype none

package rv_csr_pkg;

    // CSR address as found in the instruction's immediate field.
    typedef logic [11:0] csr_addr_t;

    // Machine trap setup.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;

    // Machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;

    // Machine information registers in the read-only range.
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // MXL of 1 for RV32.
    // Extension bits A (0), C (2), I (8) and M (12).
    localparam logic [31:0] MISA_VALUE = 32'h4000_1105;

    // Registered open-source architecture ID.
    localparam logic [31:0] MARCHID_VALUE = 32'd37;

    // Version 2.1.0.
    // Major in bits 15:8, minor in 7:4, patch in 3:0.
    localparam logic [31:0] MIMPID_VALUE = 32'h0000_0210;

    // CSR write data word.
    // Most registers take the raw word.
    // mcause keeps only the interrupt flag and the cause number.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // Set for an interrupt.
            logic        irq;
            // Not stored.
            logic [25:0] rsvd;
            // Exception or interrupt number.
            logic [4:0]  code;
        } mcause;
    } csr_wdata_u;

endpackage

`default_nettype wire

// ==== rv_trap_pkg.sv ====
// RISC-V trap definitions
`default_nettype none

package rv_trap_pkg;

    // Register width.
    localparam int XLEN = 32;

    // Cause number as stored in mcause bits 4:0.
    typedef logic [4:0] cause_t;

    // Synchronous exception codes.
    localparam cause_t ECAUSE_IALIGN   = 5'd0;
    localparam cause_t ECAUSE_IACCESS  = 5'd1;
    localparam cause_t ECAUSE_IILLEGAL = 5'd2;
    localparam cause_t ECAUSE_EBREAK   = 5'd3;
    localparam cause_t ECAUSE_LALIGN   = 5'd4;
    localparam cause_t ECAUSE_LACCESS  = 5'd5;
    localparam cause_t ECAUSE_SALIGN   = 5'd6;
    localparam cause_t ECAUSE_SACCESS  = 5'd7;
    localparam cause_t ECAUSE_M_ECALL  = 5'd11;

    // Platform interrupt lines.
    // Only these lines can ever be pending.
    localparam int IRQ_LO = 16;
    localparam int IRQ_HI = 31;

    // Pending or enable word with one bit per cause number.
    typedef logic [XLEN-1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== csr_apb_port.sv ====
// APB CSR access port
`timescale 1ns/1ps
`default_nettype none

module csr_apb_port
    import rv_csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // APB slave side.
    input  csr_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // Register file side.
    output csr_addr_t   csr_addr,
    output logic        csr_we,
    output logic        csr_re,
    output logic [31:0] csr_wdata,
    input  logic [31:0] csr_rdata,
    input  logic        csr_exists,
    input  logic        csr_rdonly
);
    // Phase decode.
    logic setup_phase;
    logic access_phase;
    // Access already served for this transfer.
    logic acc_done;
    // Transfer completes this cycle.
    logic xfer;
    // Error result of the current access.
    logic xfer_err;

    assign setup_phase  = psel && !penable;
    assign access_phase = psel && penable;

    // A new setup or an idle bus arms the next access.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_done <= 1'b0;
        end else if (setup_phase || !psel) begin
            acc_done <= 1'b0;
        end else if (access_phase) begin
            acc_done <= 1'b1;
        end
    end

    // One completion per transfer with no wait states.
    assign xfer   = access_phase && !acc_done;
    assign pready = xfer;

    // Unknown address, or a write into the read-only range.
    assign xfer_err = !csr_exists || (pwrite && csr_rdonly);
    assign pslverr  = xfer && xfer_err;

    // Address and data go straight to the decoder.
    assign csr_addr  = paddr;
    assign csr_wdata = pwdata;

    // Failed writes never reach the registers.
    assign csr_we = xfer && pwrite && !xfer_err;
    assign csr_re = xfer && !pwrite;

    // Read data only for a read that hit a CSR.
    assign prdata = (csr_re && csr_exists) ? csr_rdata : '0;

endmodule

`default_nettype wire

// ==== irq_arbiter.sv ====
// Interrupt and trap arbiter
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter
    import rv_trap_pkg::*;
#(
    // Cycles MIE must be stable before an interrupt is taken.
    parameter int mie_settle = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [IRQ_HI:IRQ_LO] irq,
    input  logic                retire_valid,
    input  logic                trap_req,
    input  cause_t              trap_cause,
    input  logic                mie_en,
    input  irq_vec_t            irq_mie,
    output irq_vec_t            irq_pending,
    output logic                take_trap,
    output logic                take_irq,
    output cause_t              take_cause
);
    // Pending lines that are also enabled.
    irq_vec_t                irq_masked;
    // Any enabled line pending.
    logic                    irq_hit;
    // Lowest pending line number.
    cause_t                  irq_cause;
    // MIE history with the newest sample in bit 0.
    logic [mie_settle-1:0]   mie_hist;
    // MIE stable long enough.
    logic                    irq_en;

    // Pin sampling.
    // Lines outside the platform range stay clear.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
        end else begin
            irq_pending                <= '0;
            irq_pending[IRQ_HI:IRQ_LO] <= irq;
        end
    end

    assign irq_masked = irq_pending & irq_mie;
    assign irq_hit    = |irq_masked[IRQ_HI:IRQ_LO];

    // Priority pick.
    // Scan downwards so the lowest line is the last match.
    always_comb begin
        irq_cause = '0;
        for (int i = IRQ_HI; i >= IRQ_LO; i--) begin
            if (irq_masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // MIE settling.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= (mie_hist << 1) | mie_settle'(mie_en);
        end
    end

    assign irq_en = (&mie_hist) && mie_en;

    // Dispatch at retire.
    // An interrupt pre-empts the retiring instruction's own trap.
    assign take_irq   = retire_valid && irq_en && irq_hit;
    assign take_trap  = retire_valid && trap_req && !take_irq;
    assign take_cause = take_irq ? irq_cause : trap_cause;

endmodule

`default_nettype wire

// ==== csr_regfile.sv ====
// Machine-mode CSR register file
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import rv_csr_pkg::*;
    import rv_trap_pkg::*;
#(
    // Value reported through mhartid.
    parameter logic [31:0] hart_id = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    // CSR access.
    input  csr_addr_t       csr_addr,
    input  logic            csr_we,
    input  logic            csr_re,
    input  csr_wdata_u      csr_wdata,
    output logic [XLEN-1:0] csr_rdata,
    output logic            csr_exists,
    output logic            csr_rdonly,
    // Trap and return events.
    input  logic            take_trap,
    input  logic            take_irq,
    input  cause_t          take_cause,
    input  logic [XLEN-1:0] trap_epc,
    input  logic [XLEN-1:0] trap_inst,
    input  logic [XLEN-1:0] trap_vaddr,
    input  logic            mret_req,
    input  irq_vec_t        irq_pending,
    // Status to the arbiter and redirect.
    output logic            mie_en,
    output irq_vec_t        irq_mie,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);
    // mstatus fields.
    // MPP is fixed to machine.
    logic              mstatus_mie;
    logic              mstatus_mpie;
    irq_vec_t          mie_q;
    logic [XLEN-1:2]   mtvec_q;
    logic [XLEN-1:0]   mscratch_q;
    logic [XLEN-1:1]   mepc_q;
    logic              mcause_int;
    cause_t            mcause_no;
    logic [XLEN-1:0]   mtval_q;
    // Trap or interrupt accepted.
    logic              trap_any;
    // CSR write that no event overrides.
    logic              wr_en;
    // Trap value for the current cause.
    logic [XLEN-1:0]   tval_sel;
    // Read mux output.
    logic [XLEN-1:0]   rd_mux;

    assign trap_any = take_trap || take_irq;
    assign wr_en    = csr_we && !trap_any && !mret_req;

    // Trap value by cause.
    always_comb begin
        tval_sel = '0;
        if (!take_irq) begin
            case (take_cause)
                ECAUSE_IALIGN, ECAUSE_IACCESS:   tval_sel = trap_epc;
                ECAUSE_IILLEGAL:                 tval_sel = trap_inst;
                ECAUSE_LALIGN, ECAUSE_LACCESS:   tval_sel = trap_vaddr;
                ECAUSE_SALIGN, ECAUSE_SACCESS:   tval_sel = trap_vaddr;
                ECAUSE_EBREAK, ECAUSE_M_ECALL:   tval_sel = '0;
                default:                         tval_sel = '0;
            endcase
        end
    end

    // Control CSRs.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mtvec_q      <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
        end else if (trap_any) begin
            // Stack the enable and record the cause.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mcause_int   <= take_irq;
            mcause_no    <= take_cause;
        end else if (mret_req) begin
            // Unstack the enable.
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (wr_en) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata.raw[3];
                    mstatus_mpie <= csr_wdata.raw[7];
                end
                CSR_MIE:    mie_q   <= csr_wdata.raw;
                CSR_MTVEC:  mtvec_q <= csr_wdata.raw[XLEN-1:2];
                CSR_MCAUSE: begin
                    mcause_int <= csr_wdata.mcause.irq;
                    mcause_no  <= csr_wdata.mcause.code;
                end
                default: ;
            endcase
        end
    end

    // Data CSRs.
    always_ff @(posedge clk) begin
        if (trap_any) begin
            mepc_q  <= trap_epc[XLEN-1:1];
            mtval_q <= tval_sel;
        end else if (wr_en) begin
            case (csr_addr)
                CSR_MSCRATCH: mscratch_q <= csr_wdata.raw;
                CSR_MEPC:     mepc_q     <= csr_wdata.raw[XLEN-1:1];
                CSR_MTVAL:    mtval_q    <= csr_wdata.raw;
                default: ;
            endcase
        end
    end

    // Read decode.
    always_comb begin
        rd_mux     = '0;
        csr_exists = 1'b1;
        case (csr_addr)
            CSR_MSTATUS:   rd_mux = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
            CSR_MISA:      rd_mux = MISA_VALUE;
            CSR_MEDELEG, CSR_MIDELEG, CSR_MSTATUSH: rd_mux = '0;
            CSR_MIE:       rd_mux = mie_q;
            CSR_MTVEC:     rd_mux = {mtvec_q, 2'b00};
            CSR_MIP:       rd_mux = irq_pending;
            CSR_MSCRATCH:  rd_mux = mscratch_q;
            CSR_MEPC:      rd_mux = {mepc_q, 1'b0};
            CSR_MCAUSE:    rd_mux = {mcause_int, {(XLEN-6){1'b0}}, mcause_no};
            CSR_MTVAL:     rd_mux = mtval_q;
            CSR_MVENDORID, CSR_MCONFIGPTR: rd_mux = '0;
            CSR_MARCHID:   rd_mux = MARCHID_VALUE;
            CSR_MIMPID:    rd_mux = MIMPID_VALUE;
            CSR_MHARTID:   rd_mux = hart_id;
            default:       csr_exists = 1'b0;
        endcase
    end

    assign csr_rdata  = csr_re ? rd_mux : '0;
    // Top two address bits set marks a read-only CSR.
    assign csr_rdonly = (csr_addr[11:10] == 2'b11);

    // Status out to the arbiter.
    assign mie_en  = mstatus_mie;
    assign irq_mie = mie_q;

    // Trap vector wins over the return address.
    assign redirect_valid = trap_any || mret_req;
    assign redirect_pc    = trap_any ? {mtvec_q, 2'b00} : {mepc_q, 1'b0};

endmodule

`default_nettype wire

// ==== trap_unit_top.sv ====
// Trap unit top level
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top
    import rv_csr_pkg::*;
    import rv_trap_pkg::*;
#(
    parameter logic [31:0] hart_id    = 32'h0000_0000,
    parameter int          mie_settle = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    // APB CSR port.
    input  csr_addr_t            paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [XLEN-1:0]      pwdata,
    output logic [XLEN-1:0]      prdata,
    output logic                 pready,
    output logic                 pslverr,
    // Retire-stage events.
    input  logic                 retire_valid,
    input  logic                 trap_req,
    input  cause_t               trap_cause,
    input  logic [XLEN-1:0]      trap_epc,
    input  logic [XLEN-1:0]      trap_inst,
    input  logic [XLEN-1:0]      trap_vaddr,
    input  logic                 mret_req,
    input  logic [IRQ_HI:IRQ_LO] irq,
    // Fetch redirect.
    output logic                 redirect_valid,
    output logic [XLEN-1:0]      redirect_pc,
    output logic                 irq_taken
);
    // Port to register file.
    csr_addr_t       csr_addr;
    logic            csr_we;
    logic            csr_re;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_exists;
    logic            csr_rdonly;
    // Arbiter and register file.
    irq_vec_t        irq_pending;
    irq_vec_t        irq_mie;
    logic            mie_en;
    logic            take_trap;
    logic            take_irq;
    cause_t          take_cause;

    csr_apb_port i_apb (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .csr_addr(csr_addr), .csr_we(csr_we), .csr_re(csr_re), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_rdonly(csr_rdonly)
    );

    irq_arbiter #(.mie_settle(mie_settle)) i_arb (
        .clk(clk), .rst(rst), .irq(irq),
        .retire_valid(retire_valid), .trap_req(trap_req), .trap_cause(trap_cause),
        .mie_en(mie_en), .irq_mie(irq_mie), .irq_pending(irq_pending),
        .take_trap(take_trap), .take_irq(take_irq), .take_cause(take_cause)
    );

    csr_regfile #(.hart_id(hart_id)) i_csr (
        .clk(clk), .rst(rst),
        .csr_addr(csr_addr), .csr_we(csr_we), .csr_re(csr_re), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_rdonly(csr_rdonly),
        .take_trap(take_trap), .take_irq(take_irq), .take_cause(take_cause),
        .trap_epc(trap_epc), .trap_inst(trap_inst), .trap_vaddr(trap_vaddr),
        .mret_req(mret_req), .irq_pending(irq_pending),
        .mie_en(mie_en), .irq_mie(irq_mie),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    // Interrupt marker for the pipeline.
    assign irq_taken = take_irq;

endmodule

`default_nettype wire

// ==== trap_unit_sva.sv ====
// Trap unit assertions
`timescale 1ns/1ps
`default_nettype none

module trap_unit_sva (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic take_trap,
    input logic take_irq,
    input logic redirect_valid,
    input logic retire_valid,
    input logic irq_taken
);

    // Completion only inside an APB access phase.
    a_pready_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    // One event kind per retire.
    a_dispatch_onehot: assert property (@(posedge clk) disable iff (rst)
        !(take_trap && take_irq))
        else $error("take_trap and take_irq high together");

    // No redirect while held in reset.
    a_reset_quiet: assert property (@(posedge clk)
        rst |-> !redirect_valid)
        else $error("redirect_valid high during reset");

    // Interrupts are only taken at a retiring instruction.
    a_irq_at_retire: assert property (@(posedge clk) disable iff (rst)
        irq_taken |-> retire_valid)
        else $error("interrupt taken without retire_valid");

endmodule

`default_nettype wire

// ==== trap_unit_tb.sv ====
// Trap unit testbench
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb
    import rv_csr_pkg::*;
    import rv_trap_pkg::*;
();
    localparam logic [31:0] HART_ID    = 32'h0000_0003;
    localparam int          RST_CYCLES = 10;
    // Spare stimulus source.
    localparam logic [15:0] LFSR_SEED  = 16'h0002;

    logic                 clk;
    logic                 rst;
    csr_addr_t            paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [XLEN-1:0]      pwdata;
    logic [XLEN-1:0]      prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 retire_valid;
    logic                 trap_req;
    cause_t               trap_cause;
    logic [XLEN-1:0]      trap_epc;
    logic [XLEN-1:0]      trap_inst;
    logic [XLEN-1:0]      trap_vaddr;
    logic                 mret_req;
    logic [IRQ_HI:IRQ_LO] irq;
    logic                 redirect_valid;
    logic [XLEN-1:0]      redirect_pc;
    logic                 irq_taken;

    // One vector per entry with op, four operands, expected word and flag.
    logic [6:0][31:0] vecs [$];
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    trap_unit_top #(.hart_id(HART_ID), .mie_settle(2)) i_dut (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .retire_valid(retire_valid), .trap_req(trap_req), .trap_cause(trap_cause),
        .trap_epc(trap_epc), .trap_inst(trap_inst), .trap_vaddr(trap_vaddr),
        .mret_req(mret_req), .irq(irq),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .irq_taken(irq_taken)
    );

    bind trap_unit_top trap_unit_sva i_sva (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
        .take_trap(take_trap), .take_irq(take_irq), .redirect_valid(redirect_valid),
        .retire_valid(retire_valid), .irq_taken(irq_taken)
    );

    // 8 ns clock.
    always #4 clk = ~clk;

    // Run limit.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding.", cycle_cnt);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Galois LFSR stepped once per bit.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        lfsr_step = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // Reads all vectors and skips comment lines.
    task automatic load_vectors();
        int               fd;
        int               n;
        string            line;
        logic [6:0][31:0] v;
        fd = $fopen("trap_unit_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open trap_unit_vectors.txt.");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                if (n != 7) begin
                    $display("Malformed vector line: %s", line);
                    abort_run();
                end
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // Setup then a single access cycle.
    // No wait states, so pready must be high in the first access cycle.
    task automatic apb_xfer(input logic wr, input csr_addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        check_bit("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Trap is accepted in its own retire cycle.
    task automatic raise_trap(input cause_t cause, input logic [31:0] epc, inst, vaddr,
                              input logic [31:0] exp_pc);
        @(posedge clk);
        #1;
        retire_valid = 1'b1;
        trap_req     = 1'b1;
        trap_cause   = cause;
        trap_epc     = epc;
        trap_inst    = inst;
        trap_vaddr   = vaddr;
        #2;
        check_bit("redirect_valid", redirect_valid, 1'b1);
        check_bit("irq_taken", irq_taken, 1'b0);
        check_word("redirect_pc", redirect_pc, exp_pc);
        @(posedge clk);
        #1;
        retire_valid = 1'b0;
        trap_req     = 1'b0;
    endtask

    task automatic issue_mret(input logic [31:0] exp_pc);
        @(posedge clk);
        #1;
        mret_req = 1'b1;
        #2;
        check_bit("redirect_valid", redirect_valid, 1'b1);
        check_word("redirect_pc", redirect_pc, exp_pc);
        @(posedge clk);
        #1;
        mret_req = 1'b0;
    endtask

    // Raise lines with a retire every cycle.
    // Either wait for the interrupt or watch that none is taken.
    task automatic wait_irq(input logic [15:0] lines, input cause_t exp_cause,
                            input int hold, input logic [31:0] exp_pc, input logic take);
        logic [31:0] rdata;
        logic        err;
        @(posedge clk);
        #1;
        irq          = lines;
        retire_valid = 1'b1;
        if (take) begin
            #2;
            while (!irq_taken) begin
                @(posedge clk);
                #3;
            end
            check_bit("redirect_valid", redirect_valid, 1'b1);
            check_word("redirect_pc", redirect_pc, exp_pc);
            @(posedge clk);
            #1;
            irq          = '0;
            retire_valid = 1'b0;
            apb_xfer(1'b0, CSR_MCAUSE, '0, rdata, err);
            check_bit("pslverr", err, 1'b0);
            check_bit("mcause.irq", rdata[31], 1'b1);
            check_cause("mcause.code", rdata[4:0], exp_cause);
        end else begin
            for (int n = 0; n < hold; n++) begin
                #2;
                check_bit("irq_taken", irq_taken, 1'b0);
                @(posedge clk);
                #1;
            end
            irq          = '0;
            retire_valid = 1'b0;
        end
    endtask

    task automatic play_vector(input int idx);
        logic [6:0][31:0] v;
        logic [31:0]      rdata;
        logic             err;
        v = vecs[idx];
        case (v[0])
            32'd1: begin
                apb_xfer(1'b1, v[1][11:0], v[2], rdata, err);
                check_bit("pslverr", err, v[6][0]);
            end
            32'd2: begin
                apb_xfer(1'b0, v[1][11:0], '0, rdata, err);
                check_bit("pslverr", err, v[6][0]);
                if (!v[6][0]) begin
                    check_word("prdata", rdata, v[5]);
                end
            end
            32'd3:   raise_trap(v[1][4:0], v[2], v[3], v[4], v[5]);
            32'd4:   issue_mret(v[5]);
            32'd5:   wait_irq(v[1][15:0], v[2][4:0], int'(v[3]), v[5], v[6][0]);
            default: begin
                $display("Unknown operation %0d in vector %0d.", v[0], idx);
                abort_run();
            end
        endcase
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        retire_valid = 1'b0;
        trap_req     = 1'b0;
        trap_cause   = '0;
        trap_epc     = '0;
        trap_inst    = '0;
        trap_vaddr   = '0;
        mret_req     = 1'b0;
        irq          = '0;
        load_vectors();
        // Twenty cycles per vector covers the longest operation.
        cycle_limit = RST_CYCLES + vecs.size() * 20;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < vecs.size(); i++) begin
            play_vector(i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== trap_unit_vectors.txt ====
# op a0 a1 a2 a3 exp_word exp_flag, all hex. 1 write addr data, 2 read addr, flag is pslverr.
# 3 trap cause epc inst vaddr, 4 mret, 5 irq lines cause hold, flag set when taken.
1 340 deadbeef 0 0 0 0
2 340 0 0 0 deadbeef 0
1 304 00240000 0 0 0 0
2 304 0 0 0 00240000 0
1 305 80001003 0 0 0 0
2 305 0 0 0 80001000 0
1 341 00002223 0 0 0 0
2 341 0 0 0 00002222 0
2 fff 0 0 0 0 1
1 f14 12345678 0 0 0 1
1 f12 0 0 0 0 1
2 f12 0 0 0 00000025 0
2 f14 0 0 0 00000003 0
1 300 00000008 0 0 0 0
2 300 0 0 0 00001808 0
3 2 00000400 0badc0de 00000777 80001000 0
2 341 0 0 0 00000400 0
2 343 0 0 0 0badc0de 0
2 342 0 0 0 00000002 0
2 300 0 0 0 00001880 0
1 300 00000008 0 0 0 0
3 5 00000504 00000013 10000020 80001000 0
2 343 0 0 0 10000020 0
4 0 0 0 0 00000504 0
2 300 0 0 0 00001888 0
5 0001 0 c 0 0 0
5 0024 12 0 0 80001000 1
2 342 0 0 0 80000012 0

// ==== flist.f ====
rv_csr_pkg.sv
rv_trap_pkg.sv
csr_apb_port.sv
irq_arbiter.sv
csr_regfile.sv
trap_unit_top.sv
trap_unit_sva.sv
trap_unit_tb.sv

// ==== Bender.yml ====
package:
  name: trap_unit

sources:
  - rv_csr_pkg.sv
  - rv_trap_pkg.sv
  - csr_apb_port.sv
  - irq_arbiter.sv
  - csr_regfile.sv
  - trap_unit_top.sv
  - target: test
    files:
      - trap_unit_sva.sv
      - trap_unit_tb.sv
